//--- design/ntt_pkg.sv
// ==========================================================
// Shared constants, mode and op encodings for the NTT core
// Field is Q = 8380417, polynomials hold 16 coefficients
// All coefficients are assumed already reduced below Q
// Twiddle helpers are constant functions meant for use at
// elaboration, not as run time hardware
// ==========================================================

package ntt_pkg;

    // Field and polynomial geometry
    localparam int coef_w = 23;
    localparam int ntt_n  = 16;
    localparam int addr_w = 4;
    localparam int log_n  = 4;

    localparam logic [coef_w-1:0] mldsa_q = 23'd8380417;
    // 16^-1 mod Q
    localparam logic [coef_w-1:0] n_inv   = 23'd7856641;

    typedef enum logic [2:0] {
        mode_ct, mode_gs, mode_pwm, mode_pwa, mode_pws
    } mode_t;

    typedef enum logic [2:0] {
        op_ct, op_gs, op_scale, op_mul, op_add, op_sub
    } op_t;

    // Primitive 32nd root, taken as 1753^16 with 1753 the 512th root
    function automatic logic [coef_w-1:0] root32();
        logic [63:0] acc;
        acc = 64'd1;
        for (int i = 0; i < 16; i++) begin
            acc = (acc * 64'd1753) % 64'(mldsa_q);
        end
        return coef_w'(acc);
    endfunction

    // k-th power of the 32nd root, reduced mod Q
    function automatic logic [coef_w-1:0] zeta_pow(input int unsigned k);
        logic [63:0] acc;
        logic [63:0] w;
        acc = 64'd1;
        w   = 64'(root32());
        for (int unsigned i = 0; i < k; i++) begin
            acc = (acc * w) % 64'(mldsa_q);
        end
        return coef_w'(acc);
    endfunction

    // Bit reversal of a 4-bit index for twiddle ordering
    function automatic logic [3:0] bitrev4(input logic [3:0] x);
        return {x[0], x[1], x[2], x[3]};
    endfunction

endpackage

//--- design/ntt_mem.sv
// ==========================================================
// Two-port coefficient RAM, 16 words, registered read data
// Read latency is one cycle after the port enable
// A read during a write on the same port returns old data
// Same-address writes from both ports are not resolved
// Zeroize clears the array and both output registers
// ==========================================================

module ntt_mem (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        zeroize,
    input  logic                        en_a,
    input  logic                        we_a,
    input  logic [ntt_pkg::addr_w-1:0]  addr_a,
    input  logic [ntt_pkg::coef_w-1:0]  wdata_a,
    output logic [ntt_pkg::coef_w-1:0]  rdata_a,
    input  logic                        en_b,
    input  logic                        we_b,
    input  logic [ntt_pkg::addr_w-1:0]  addr_b,
    input  logic [ntt_pkg::coef_w-1:0]  wdata_b,
    output logic [ntt_pkg::coef_w-1:0]  rdata_b
);
    import ntt_pkg::*;

    logic [coef_w-1:0] mem_q [ntt_n];

    // Storage array, both write ports in one process
    always_ff @(posedge clk) begin
        if (zeroize) begin
            for (int i = 0; i < ntt_n; i++) begin
                mem_q[i] <= '0;
            end
        end else begin
            if (en_a && we_a) begin
                mem_q[addr_a] <= wdata_a;
            end
            if (en_b && we_b) begin
                mem_q[addr_b] <= wdata_b;
            end
        end
    end

    // Output registers, loaded on any enabled access
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata_a <= '0;
            rdata_b <= '0;
        end else if (zeroize) begin
            rdata_a <= '0;
            rdata_b <= '0;
        end else begin
            if (en_a) rdata_a <= mem_q[addr_a];
            if (en_b) rdata_b <= mem_q[addr_b];
        end
    end

endmodule

//--- design/ntt_butterfly.sv
// ==========================================================
// Modular datapath with one register stage
// Inputs u, v and tw must already be below Q
// Multiply is a full product followed by a remainder by Q,
// so the compute cycle carries a long combinational path
// out_v is don't-care for the pointwise ops
// ==========================================================

module ntt_butterfly (
    input  logic                        clk,
    input  logic                        arst_n,
    input  ntt_pkg::op_t                op,
    input  logic [ntt_pkg::coef_w-1:0]  u,
    input  logic [ntt_pkg::coef_w-1:0]  v,
    input  logic [ntt_pkg::coef_w-1:0]  tw,
    output logic [ntt_pkg::coef_w-1:0]  out_u,
    output logic [ntt_pkg::coef_w-1:0]  out_v
);
    import ntt_pkg::*;

    // ======================================================
    // Modular helpers
    // ======================================================

    function automatic logic [coef_w-1:0] add_mod(input logic [coef_w-1:0] a,
                                                  input logic [coef_w-1:0] b);
        logic [coef_w:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= {1'b0, mldsa_q}) begin
            s = s - {1'b0, mldsa_q};
        end
        return s[coef_w-1:0];
    endfunction

    // Wraps through 2^23 when a < b, true result still fits
    function automatic logic [coef_w-1:0] sub_mod(input logic [coef_w-1:0] a,
                                                  input logic [coef_w-1:0] b);
        if (a >= b) begin
            return a - b;
        end
        return a - b + mldsa_q;
    endfunction

    function automatic logic [coef_w-1:0] mul_mod(input logic [coef_w-1:0] a,
                                                  input logic [coef_w-1:0] b);
        logic [2*coef_w-1:0] prod;
        prod = (2*coef_w)'(a) * (2*coef_w)'(b);
        return coef_w'(prod % (2*coef_w)'(mldsa_q));
    endfunction

    // ======================================================
    // Shared operators
    // ======================================================

    logic [coef_w-1:0] sum_uv;
    logic [coef_w-1:0] dif_uv;
    logic [coef_w-1:0] m0_a;
    logic [coef_w-1:0] m0_b;
    logic [coef_w-1:0] m1_a;
    logic [coef_w-1:0] prod0;
    logic [coef_w-1:0] prod1;
    logic [coef_w-1:0] res_u;
    logic [coef_w-1:0] res_v;

    assign sum_uv = add_mod(u, v);
    assign dif_uv = sub_mod(u, v);

    // Multiplier 0 takes tw*v for CT, u*tw for scaling, u*v pointwise
    assign m0_a  = (op == op_ct) ? v : u;
    assign m0_b  = (op == op_mul) ? v : tw;
    assign prod0 = mul_mod(m0_a, m0_b);

    // Multiplier 1 takes (u-v)*tw for GS and v*tw for scaling
    assign m1_a  = (op == op_gs) ? dif_uv : v;
    assign prod1 = mul_mod(m1_a, tw);

    always_comb begin
        case (op)
            op_ct: begin
                res_u = add_mod(u, prod0);
                res_v = sub_mod(u, prod0);
            end
            op_gs: begin
                res_u = sum_uv;
                res_v = prod1;
            end
            op_scale: begin
                res_u = prod0;
                res_v = prod1;
            end
            op_mul: begin
                res_u = prod0;
                res_v = v;
            end
            op_add: begin
                res_u = sum_uv;
                res_v = v;
            end
            op_sub: begin
                res_u = dif_uv;
                res_v = v;
            end
            default: begin
                res_u = '0;
                res_v = '0;
            end
        endcase
    end

    // Result register, valid in the write phase of the step
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_u <= '0;
            out_v <= '0;
        end else begin
            out_u <= res_u;
            out_v <= res_v;
        end
    end

endmodule

//--- design/ntt_ctrl.sv
// ==========================================================
// Sequencer for NTT stages, scaling pass and pointwise sweep
// Each step is read, compute, write, and steps never overlap
// ct takes 96 busy cycles, gs 120 including the N^-1 pass
// Pointwise works one coefficient per step, v coming from
// memory B, so a pointwise run takes 48 busy cycles
// mode is sampled only in the accepting cycle
// ==========================================================

module ntt_ctrl (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        zeroize,
    input  ntt_pkg::mode_t              mode,
    input  logic                        ntt_enable,
    output logic                        ntt_busy,
    output logic                        ntt_done,
    output logic                        rd_en_a,
    output logic [ntt_pkg::addr_w-1:0]  addr_u,
    output logic [ntt_pkg::addr_w-1:0]  addr_v,
    output logic                        wr_en_a,
    output logic                        rd_en_b,
    output ntt_pkg::op_t                op,
    output logic [ntt_pkg::coef_w-1:0]  tw
);
    import ntt_pkg::*;

    logic              busy_q;
    logic [1:0]        phase_q;
    logic [addr_w-1:0] step_q;
    logic [1:0]        stage_q;
    logic              scale_q;
    mode_t             mode_q;

    logic              pw_mode;
    logic [1:0]        len_log;
    logic [addr_w-1:0] len;
    logic [addr_w-1:0] grp;
    logic [addr_w-1:0] offs;
    logic [addr_w-1:0] addr_bf;
    logic [addr_w-1:0] k_fwd;
    logic [addr_w:0]   k_inv;
    logic              last_step;
    logic              last_op;

    logic [coef_w-1:0] tw_fwd [ntt_n];
    logic [coef_w-1:0] tw_inv [ntt_n];

    // Twiddle ROMs, constant per entry; GS uses the negated zetas
    for (genvar k = 0; k < ntt_n; k++) begin : g_tw
        assign tw_fwd[k] = zeta_pow(bitrev4(4'(k)));
        assign tw_inv[k] = mldsa_q - zeta_pow(bitrev4(4'(k)));
    end

    // ======================================================
    // Address and twiddle generation
    // ======================================================

    assign pw_mode = mode_q inside {mode_pwm, mode_pwa, mode_pws};

    // Half-span is 8,4,2,1 going forward and 1,2,4,8 going back
    assign len_log = (mode_q == mode_ct) ? 2'd3 - stage_q : stage_q;
    assign len     = addr_w'(1) << len_log;
    assign grp     = step_q >> len_log;
    assign offs    = step_q & (len - 1'b1);
    // Insert a zero at bit len_log of the step to get the lower index
    assign addr_bf = ((grp << len_log) << 1) | offs;

    // CT walks k = 1..15, GS walks k = 15..1
    assign k_fwd = (addr_w'(1) << stage_q) + grp;
    assign k_inv = ((addr_w+1)'(ntt_n) >> stage_q) - 5'd1 - {1'b0, grp};

    always_comb begin
        if (pw_mode) begin
            addr_u = step_q;
            addr_v = step_q;
        end else if (scale_q) begin
            addr_u = {step_q[2:0], 1'b0};
            addr_v = {step_q[2:0], 1'b1};
        end else begin
            addr_u = addr_bf;
            addr_v = addr_bf | len;
        end
    end

    always_comb begin
        case (mode_q)
            mode_ct:  op = op_ct;
            mode_gs:  op = scale_q ? op_scale : op_gs;
            mode_pwm: op = op_mul;
            mode_pwa: op = op_add;
            default:  op = op_sub;
        endcase
    end

    always_comb begin
        if (pw_mode) tw = '0;
        else if (scale_q) tw = n_inv;
        else if (mode_q == mode_ct) tw = tw_fwd[k_fwd];
        else tw = tw_inv[k_inv[addr_w-1:0]];
    end

    // ======================================================
    // Step, stage and phase sequencing
    // ======================================================

    assign last_step = pw_mode ? (step_q == 4'd15) : (step_q == 4'd7);
    assign last_op   = last_step &&
                       (pw_mode || scale_q || (stage_q == 2'd3 && mode_q == mode_ct));

    // Phase 0 issues reads, phase 2 writes the registered result
    assign ntt_busy = busy_q;
    assign ntt_done = busy_q && (phase_q == 2'd2) && last_op;
    assign rd_en_a  = busy_q && (phase_q == 2'd0);
    assign rd_en_b  = rd_en_a && pw_mode;
    assign wr_en_a  = busy_q && (phase_q == 2'd2);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q  <= 1'b0;
            phase_q <= 2'd0;
            step_q  <= '0;
            stage_q <= 2'd0;
            scale_q <= 1'b0;
            mode_q  <= mode_ct;
        end else if (zeroize) begin
            // Abort back to idle
            busy_q  <= 1'b0;
            phase_q <= 2'd0;
            step_q  <= '0;
            stage_q <= 2'd0;
            scale_q <= 1'b0;
        end else if (!busy_q) begin
            if (ntt_enable) begin
                busy_q  <= 1'b1;
                mode_q  <= mode;
                phase_q <= 2'd0;
                step_q  <= '0;
                stage_q <= 2'd0;
                scale_q <= 1'b0;
            end
        end else if (phase_q != 2'd2) begin
            phase_q <= phase_q + 2'd1;
        end else begin
            phase_q <= 2'd0;
            if (last_op) begin
                busy_q  <= 1'b0;
                step_q  <= '0;
                stage_q <= 2'd0;
                scale_q <= 1'b0;
            end else if (last_step) begin
                step_q <= '0;
                // Only gs gets past stage 3 here, into the N^-1 pass
                if (stage_q == 2'd3) scale_q <= 1'b1;
                else stage_q <= stage_q + 2'd1;
            end else begin
                step_q <= step_q + 4'd1;
            end
        end
    end

endmodule

//--- design/ntt_subsystem.sv
// ==========================================================
// NTT subsystem, memory A (working) and memory B (operand)
// Host port reaches port a of either memory only while idle
// host_rdata follows host_en by one cycle
// NTT and pointwise results are written back into memory A
// ==========================================================

module ntt_subsystem (
    input  logic                        clk,
    input  logic                        arst_n,
    input  ntt_pkg::mode_t              mode,
    input  logic                        ntt_enable,
    input  logic                        zeroize,
    output logic                        ntt_busy,
    output logic                        ntt_done,
    input  logic                        host_en,
    input  logic                        host_we,
    input  logic                        host_sel,
    input  logic [ntt_pkg::addr_w-1:0]  host_addr,
    input  logic [ntt_pkg::coef_w-1:0]  host_wdata,
    output logic [ntt_pkg::coef_w-1:0]  host_rdata
);
    import ntt_pkg::*;

    // Engine side
    logic              rd_en_a;
    logic              rd_en_b;
    logic              wr_en_a;
    logic [addr_w-1:0] addr_u;
    logic [addr_w-1:0] addr_v;
    op_t               op;
    logic [coef_w-1:0] tw;
    logic [coef_w-1:0] out_u;
    logic [coef_w-1:0] out_v;
    logic              pw_op;

    // Memory data
    logic [coef_w-1:0] a_rdata_a;
    logic [coef_w-1:0] a_rdata_b;
    logic [coef_w-1:0] b_rdata_a;
    logic [coef_w-1:0] bfly_v;

    // Host side
    logic host_go;
    logic host_sel_q;

    assign host_go = host_en && !ntt_busy;
    assign pw_op   = op inside {op_mul, op_add, op_sub};
    // Second operand is A's upper word for NTT, memory B pointwise
    assign bfly_v  = pw_op ? b_rdata_a : a_rdata_b;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) host_sel_q <= 1'b0;
        else if (host_go) host_sel_q <= host_sel;
    end

    assign host_rdata = host_sel_q ? b_rdata_a : a_rdata_a;

    ntt_ctrl ctrl_i (
        .clk(clk), .arst_n(arst_n), .zeroize(zeroize),
        .mode(mode), .ntt_enable(ntt_enable),
        .ntt_busy(ntt_busy), .ntt_done(ntt_done),
        .rd_en_a(rd_en_a), .addr_u(addr_u), .addr_v(addr_v),
        .wr_en_a(wr_en_a), .rd_en_b(rd_en_b), .op(op), .tw(tw)
    );

    ntt_butterfly bfly_i (
        .clk(clk), .arst_n(arst_n), .op(op),
        .u(a_rdata_a), .v(bfly_v), .tw(tw),
        .out_u(out_u), .out_v(out_v)
    );

    // Port a shared with the host, port b engine only and idle pointwise
    ntt_mem mem_a_i (
        .clk(clk), .arst_n(arst_n), .zeroize(zeroize),
        .en_a(ntt_busy ? (rd_en_a || wr_en_a) : (host_go && !host_sel)),
        .we_a(ntt_busy ? wr_en_a : host_we),
        .addr_a(ntt_busy ? addr_u : host_addr),
        .wdata_a(ntt_busy ? out_u : host_wdata),
        .rdata_a(a_rdata_a),
        .en_b((rd_en_a || wr_en_a) && !pw_op),
        .we_b(wr_en_a), .addr_b(addr_v), .wdata_b(out_v),
        .rdata_b(a_rdata_b)
    );

    // Engine only reads B, through port a; port b stays unused
    ntt_mem mem_b_i (
        .clk(clk), .arst_n(arst_n), .zeroize(zeroize),
        .en_a(ntt_busy ? rd_en_b : (host_go && host_sel)),
        .we_a(!ntt_busy && host_we),
        .addr_a(ntt_busy ? addr_u : host_addr),
        .wdata_a(host_wdata), .rdata_a(b_rdata_a),
        .en_b(1'b0), .we_b(1'b0), .addr_b('0), .wdata_b('0),
        .rdata_b()
    );

endmodule

//--- test/ntt_assert.sv
// ==========================================================
// Protocol and isolation checks, bound into ntt_subsystem
// Assumes ntt_enable is a single-cycle pulse
// fail_cnt counts assertion failures for the testbench
// ==========================================================

module ntt_assert (
    input logic                        clk,
    input logic                        arst_n,
    input logic                        zeroize,
    input logic                        ntt_enable,
    input logic                        ntt_busy,
    input logic                        ntt_done,
    input logic                        rd_en_a,
    input logic                        rd_en_b,
    input logic                        wr_en_a,
    input logic [ntt_pkg::coef_w-1:0]  out_u
);
    timeunit 1ns;
    timeprecision 100ps;
    import ntt_pkg::*;

    int unsigned fail_cnt = 0;
    logic [7:0]  busy_cycles;

    // Busy cycles since acceptance, cleared when idle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_cycles <= '0;
        end else if (!ntt_busy) begin
            busy_cycles <= '0;
        end else begin
            busy_cycles <= busy_cycles + 8'd1;
        end
    end

    // ======================================================
    // Status protocol
    // ======================================================

    a_reset_idle: assert property (@(posedge clk)
        !arst_n |-> !ntt_busy && !ntt_done && !rd_en_a && !rd_en_b && !wr_en_a)
        else begin
            fail_cnt++;
            $error("status or engine enable high in reset");
        end

    a_done_in_busy: assert property (@(posedge clk) disable iff (!arst_n)
        ntt_done |-> ntt_busy)
        else begin
            fail_cnt++;
            $error("ntt_done outside a busy period");
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        ntt_done |=> !ntt_done)
        else begin
            fail_cnt++;
            $error("ntt_done longer than one cycle");
        end

    a_busy_falls: assert property (@(posedge clk) disable iff (!arst_n)
        ntt_done |=> !ntt_busy)
        else begin
            fail_cnt++;
            $error("ntt_busy still high after ntt_done");
        end

    a_busy_rises: assert property (@(posedge clk) disable iff (!arst_n)
        (ntt_enable && !ntt_busy && !zeroize) |=> ntt_busy)
        else begin
            fail_cnt++;
            $error("accepted enable did not raise ntt_busy");
        end

    a_busy_holds: assert property (@(posedge clk) disable iff (!arst_n)
        (ntt_busy && !ntt_done && !zeroize) |=> ntt_busy)
        else begin
            fail_cnt++;
            $error("ntt_busy dropped without ntt_done");
        end

    a_done_bound: assert property (@(posedge clk) disable iff (!arst_n)
        ntt_busy |-> busy_cycles < 8'd130)
        else begin
            fail_cnt++;
            $error("no ntt_done within 130 cycles");
        end

    a_zeroize_idle: assert property (@(posedge clk) disable iff (!arst_n)
        zeroize |=> !ntt_busy)
        else begin
            fail_cnt++;
            $error("engine still busy after zeroize");
        end

    // ======================================================
    // Memory isolation and result range
    // ======================================================

    a_idle_enables: assert property (@(posedge clk) disable iff (!arst_n)
        !ntt_busy |-> !rd_en_a && !rd_en_b && !wr_en_a)
        else begin
            fail_cnt++;
            $error("engine memory enable while idle");
        end

    a_result_range: assert property (@(posedge clk) disable iff (!arst_n)
        wr_en_a |-> out_u < mldsa_q)
        else begin
            fail_cnt++;
            $error("written coefficient not reduced below Q");
        end

endmodule

bind ntt_subsystem ntt_assert assert_i (
    .clk(clk), .arst_n(arst_n), .zeroize(zeroize),
    .ntt_enable(ntt_enable), .ntt_busy(ntt_busy), .ntt_done(ntt_done),
    .rd_en_a(rd_en_a), .rd_en_b(rd_en_b), .wr_en_a(wr_en_a),
    .out_u(out_u)
);

//--- test/ntt_tb.sv
// ==========================================================
// Testbench for ntt_subsystem
// Checks host readback against a model of both memories
// NTT results are checked by identities only (constant
// input, ct then gs round trip), no full transform model
// Protocol checks live in the bound assertion module
// ==========================================================

module ntt_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import ntt_pkg::*;

    // About 1400 cycles of tests, roughly doubled as margin
    localparam int max_cycles = 3000;

    logic              clk;
    logic              arst_n;
    mode_t             mode;
    logic              ntt_enable;
    logic              zeroize;
    logic              ntt_busy;
    logic              ntt_done;
    logic              host_en;
    logic              host_we;
    logic              host_sel;
    logic [addr_w-1:0] host_addr;
    logic [coef_w-1:0] host_wdata;
    logic [coef_w-1:0] host_rdata;

    // Expected contents of memory A and memory B
    logic [coef_w-1:0] model_a [ntt_n];
    logic [coef_w-1:0] model_b [ntt_n];
    logic [coef_w-1:0] c_val;
    int                seed = 32'h6df6;
    int                rd_errors = 0;
    int                cycles = 0;

    ntt_subsystem dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: run did not finish within %0d cycles", max_cycles);
            $display("Verification failed");
            $finish;
        end
    end

    // Field arithmetic straight from the definitions, 64-bit wide
    function automatic logic [coef_w-1:0] expect_pw(input mode_t m,
                                                    input logic [coef_w-1:0] a,
                                                    input logic [coef_w-1:0] b);
        logic [63:0] r;
        case (m)
            mode_pwm: r = (64'(a) * 64'(b)) % 64'(mldsa_q);
            mode_pwa: r = (64'(a) + 64'(b)) % 64'(mldsa_q);
            default:  r = (64'(a) + 64'(mldsa_q) - 64'(b)) % 64'(mldsa_q);
        endcase
        return coef_w'(r);
    endfunction

    task automatic next_coef(output logic [coef_w-1:0] v);
        logic [31:0] r;
        r = $random(seed);
        v = coef_w'(r % 32'(mldsa_q));
    endtask

    task automatic write_word(input logic sel, input logic [addr_w-1:0] addr,
                              input logic [coef_w-1:0] data);
        @(posedge clk);
        host_en    <= 1'b1;
        host_we    <= 1'b1;
        host_sel   <= sel;
        host_addr  <= addr;
        host_wdata <= data;
        @(posedge clk);
        host_en <= 1'b0;
        host_we <= 1'b0;
    endtask

    // Request, then one cycle of RAM latency, then compare
    task automatic read_check(input logic sel, input logic [addr_w-1:0] addr,
                              input logic [coef_w-1:0] exp);
        @(posedge clk);
        host_en   <= 1'b1;
        host_we   <= 1'b0;
        host_sel  <= sel;
        host_addr <= addr;
        @(posedge clk);
        host_en <= 1'b0;
        @(posedge clk);
        if (host_rdata !== exp) begin
            rd_errors++;
            $display("FAIL host_rdata mem %s addr 0x%h: expected 0x%h, got 0x%h",
                     sel ? "B" : "A", addr, exp, host_rdata);
        end
    endtask

    task automatic load_poly(input logic sel);
        for (int i = 0; i < ntt_n; i++) begin
            write_word(sel, addr_w'(i), sel ? model_b[i] : model_a[i]);
        end
    endtask

    task automatic check_poly(input logic sel);
        for (int i = 0; i < ntt_n; i++) begin
            read_check(sel, addr_w'(i), sel ? model_b[i] : model_a[i]);
        end
    endtask

    task automatic start_op(input mode_t m);
        @(posedge clk);
        mode       <= m;
        ntt_enable <= 1'b1;
        @(posedge clk);
        ntt_enable <= 1'b0;
    endtask

    // Done is seen at the edge closing the last busy cycle
    task automatic wait_done();
        do @(posedge clk); while (!ntt_done);
    endtask

    task automatic run_pointwise(input mode_t m);
        start_op(m);
        wait_done();
        for (int i = 0; i < ntt_n; i++) begin
            model_a[i] = expect_pw(m, model_a[i], model_b[i]);
        end
        check_poly(1'b0);
    endtask

    initial begin
        arst_n     = 1'b0;
        mode       = mode_ct;
        ntt_enable = 1'b0;
        zeroize    = 1'b0;
        host_en    = 1'b0;
        host_we    = 1'b0;
        host_sel   = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;

        // ==================================================
        // Host load and readback, then pointwise ops
        // ==================================================
        for (int i = 0; i < ntt_n; i++) begin
            next_coef(model_a[i]);
            next_coef(model_b[i]);
        end
        load_poly(1'b0);
        load_poly(1'b1);
        check_poly(1'b0);
        check_poly(1'b1);
        run_pointwise(mode_pwm);
        run_pointwise(mode_pwa);
        run_pointwise(mode_pws);
        check_poly(1'b1);

        // Forward NTT of c at index 0 gives c everywhere
        next_coef(c_val);
        for (int i = 0; i < ntt_n; i++) model_a[i] = (i == 0) ? c_val : '0;
        load_poly(1'b0);
        start_op(mode_ct);
        wait_done();
        for (int i = 0; i < ntt_n; i++) model_a[i] = c_val;
        check_poly(1'b0);

        // ct then gs returns the input, B left alone
        for (int i = 0; i < ntt_n; i++) next_coef(model_a[i]);
        load_poly(1'b0);
        start_op(mode_ct);
        wait_done();
        start_op(mode_gs);
        wait_done();
        check_poly(1'b0);
        check_poly(1'b1);

        // ==================================================
        // Enable and host write while busy are both ignored
        // ==================================================
        start_op(mode_pws);
        next_coef(c_val);
        @(posedge clk);
        mode       <= mode_pwm;
        ntt_enable <= 1'b1;
        host_en    <= 1'b1;
        host_we    <= 1'b1;
        host_sel   <= 1'b1;
        host_addr  <= 4'd5;
        host_wdata <= c_val;
        @(posedge clk);
        ntt_enable <= 1'b0;
        host_en    <= 1'b0;
        host_we    <= 1'b0;
        wait_done();
        for (int i = 0; i < ntt_n; i++) begin
            model_a[i] = expect_pw(mode_pws, model_a[i], model_b[i]);
        end
        check_poly(1'b0);
        read_check(1'b1, 4'd5, model_b[5]);

        // Zeroize in the middle of a gs run
        start_op(mode_gs);
        repeat (5) @(posedge clk);
        zeroize <= 1'b1;
        @(posedge clk);
        zeroize <= 1'b0;
        @(posedge clk);
        if (ntt_busy) begin
            rd_errors++;
            $display("FAIL ntt_busy after zeroize: expected 0x0, got 0x%h", ntt_busy);
        end
        for (int i = 0; i < ntt_n; i++) begin
            model_a[i] = '0;
            model_b[i] = '0;
        end
        check_poly(1'b0);
        check_poly(1'b1);

        repeat (2) @(posedge clk);
        $display("Readback errors: %0d, assertion failures: %0d",
                 rd_errors, dut_i.assert_i.fail_cnt);
        if (rd_errors == 0 && dut_i.assert_i.fail_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- sources.f
design/ntt_pkg.sv
design/ntt_mem.sv
design/ntt_butterfly.sv
design/ntt_ctrl.sv
design/ntt_subsystem.sv
test/ntt_assert.sv
test/ntt_tb.sv

//--- Makefile
# Verilator build and run for the NTT subsystem testbench

VERILATOR ?= verilator
TOP       ?= ntt_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(SIM) $(RUN_ARGS) | tee $(LOG)
	@grep -q "Verification passed" $(LOG) || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
